// File: source/aib_rx_config.svh
// Receive channel sizing
`ifndef AIB_RX_CONFIG_SVH
`define AIB_RX_CONFIG_SVH

// Raw link word from the I/O buffers
`define AIB_RX_WORD_W 80

// One DBI lane, 19 data bits plus the inversion flag on top
`define AIB_RX_LANE_W 20

// Words per read word in 4:1 mode
`define AIB_RX_PACK 4

// FIFO address width, 8 entries
`define AIB_RX_FIFO_AW 3

`endif

// File: source/aib_rx_pkg.sv
// Receive channel types
`include "aib_rx_config.svh"

package aib_rx_pkg;

   // One raw or decoded link word
   typedef logic [`AIB_RX_WORD_W-1:0] rx_word_t;

   // Read word, first-received link word in the low bits
   typedef logic [`AIB_RX_PACK*`AIB_RX_WORD_W-1:0] rx_pack_t;

   // Word as seen by the FIFO write side
   typedef struct packed {
      rx_word_t data;
      logic     sof;    // First word of a group
      logic     valid;  // Word is to be written
   } rx_beat_t;

   // Static configuration, stable before reset release
   typedef struct packed {
      logic [1:0] fifo_mode;  // 0 is 1:1, 1 is 4:1
      logic [3:0] rd_delay;   // Phase compensation fill
      logic       wa_en;
      logic       swap_en;
      logic [4:0] mkbit;      // Marker position in the raw word
      logic       dbi_en;
   } rx_cfg_t;

   // Status outputs
   typedef struct packed {
      logic       align_done;
      logic       wa_error;       // Sticky
      logic [3:0] wa_error_cnt;   // Saturates at 15
      logic       fifo_overflow;  // Sticky
   } rx_status_t;

endpackage

// File: source/aib_rx_dbi_decoder.sv
// DBI decoder
`timescale 1ns/10ps
`include "aib_rx_config.svh"

module aib_rx_dbi_decoder (
   input  logic                 rxfifo_wrclk,
   input  logic                 arst_n,
   input  aib_rx_pkg::rx_word_t din,
   input  logic                 dbi_en,
   output aib_rx_pkg::rx_word_t dec_word
);
   import aib_rx_pkg::*;

   localparam int LW    = `AIB_RX_LANE_W;
   localparam int LANES = `AIB_RX_WORD_W / `AIB_RX_LANE_W;

   logic [1:0] rst_sync;
   logic       rst_n;
   rx_word_t   dec_next;

   // Reset release aligned to the write clock
   always_ff @(posedge rxfifo_wrclk or negedge arst_n) begin
      if (!arst_n) begin
         rst_sync <= 2'b00;
      end else begin
         rst_sync <= {rst_sync[0], 1'b1};
      end
   end

   assign rst_n = rst_sync[1];

   always_comb begin
      dec_next = din;
      if (dbi_en) begin
         for (int l = 0; l < LANES; l++) begin
            // Flag set means the lane was sent inverted
            dec_next[l*LW +: LW-1] = din[l*LW +: LW-1] ^ {(LW-1){din[l*LW+LW-1]}};
            dec_next[l*LW+LW-1]    = 1'b0;  // Flags never reach the payload
         end
      end
   end

   always_ff @(posedge rxfifo_wrclk or negedge rst_n) begin
      if (!rst_n) begin
         dec_word <= '0;
      end else begin
         dec_word <= dec_next;
      end
   end

endmodule

// File: source/aib_rx_word_aligner.sv
// Word aligner
// Marker search and group phase tracking
`timescale 1ns/10ps

module aib_rx_word_aligner (
   input  logic                 rxfifo_wrclk,
   input  logic                 arst_n,
   input  aib_rx_pkg::rx_word_t din,
   input  aib_rx_pkg::rx_cfg_t  cfg,
   output aib_rx_pkg::rx_beat_t wa_beat,
   output logic                 align_done,
   output logic                 wa_error,
   output logic [3:0]           wa_error_cnt
);
   import aib_rx_pkg::*;

   logic [1:0] rst_sync;
   logic       rst_n;
   logic       mode_4to1;
   logic       marker;
   logic       locked;      // Marker found, phase is tracked
   logic [1:0] phase;       // Position of the next word in its group
   logic       beat_sof;
   logic       beat_valid;

   always_ff @(posedge rxfifo_wrclk or negedge arst_n) begin
      if (!arst_n) begin
         rst_sync <= 2'b00;
      end else begin
         rst_sync <= {rst_sync[0], 1'b1};
      end
   end

   assign rst_n     = rst_sync[1];
   assign mode_4to1 = (cfg.fifo_mode == 2'd1);
   assign marker    = din[cfg.mkbit];

   always_ff @(posedge rxfifo_wrclk or negedge rst_n) begin
      if (!rst_n) begin
         locked       <= 1'b0;
         phase        <= 2'd0;
         beat_sof     <= 1'b0;
         beat_valid   <= 1'b0;
         align_done   <= 1'b0;
         wa_error     <= 1'b0;
         wa_error_cnt <= 4'd0;
      end else if (!mode_4to1) begin
         beat_valid <= 1'b1;  // Every word is its own group
         beat_sof   <= 1'b1;
      end else if (!cfg.wa_en) begin
         // Free running groups from the first word after reset
         beat_valid <= 1'b1;
         beat_sof   <= (phase == 2'd0);
         phase      <= phase + 2'd1;
      end else if (!locked) begin
         beat_valid <= marker;  // Discard until the first marker
         beat_sof   <= marker;
         if (marker) begin
            locked     <= 1'b1;
            align_done <= 1'b1;
            phase      <= 2'd1;
         end
      end else begin
         beat_valid <= 1'b1;
         beat_sof   <= (phase == 2'd0);
         phase      <= phase + 2'd1;
         // Pattern is 1,0,0,0 and the phase is kept on a mismatch
         if (marker != (phase == 2'd0)) begin
            wa_error <= 1'b1;
            if (wa_error_cnt != 4'hf) begin
               wa_error_cnt <= wa_error_cnt + 4'd1;
            end
         end
      end
   end

   // Payload comes from the decoder
   assign wa_beat = rx_beat_t'{data: '0, sof: beat_sof, valid: beat_valid};

endmodule

// File: source/aib_rx_fifo.sv
// Receive FIFO
// Packing, clock crossing and req/ack read port
`timescale 1ns/10ps
`include "aib_rx_config.svh"

module aib_rx_fifo (
   input  logic                 rxfifo_wrclk,
   input  logic                 m_rd_clk,
   input  logic                 arst_n,
   input  aib_rx_pkg::rx_cfg_t  cfg,
   input  aib_rx_pkg::rx_word_t dec_word,
   input  aib_rx_pkg::rx_beat_t wa_beat,
   output aib_rx_pkg::rx_pack_t rd_data,
   output logic                 rd_req,
   input  logic                 rd_ack,
   output logic                 fifo_overflow
);
   import aib_rx_pkg::*;

   localparam int AW    = `AIB_RX_FIFO_AW;
   localparam int DEPTH = 1 << AW;
   localparam int WW    = `AIB_RX_WORD_W;
   localparam int HW    = WW / 2;
   localparam int PACK  = `AIB_RX_PACK;
   localparam int CW    = $clog2(PACK);
   localparam logic [CW-1:0] LAST = CW'(PACK - 1);

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_REQ,
      RD_RELEASE
   } rd_state_t;

   logic [1:0]            wr_rst_sync;
   logic                  wr_rst_n;
   logic [1:0]            rd_rst_sync;
   logic                  rd_rst_n;
   logic                  mode_4to1;
   rx_word_t [PACK-2:0]   pack_buf;
   logic [CW-1:0]         pack_cnt;
   rx_pack_t              wr_data;
   logic                  wr_push;
   rx_pack_t              mem [DEPTH];
   logic [AW:0]           wr_ptr;
   logic [AW:0]           wr_gray;
   logic [AW:0]           rd_gray_w1;
   logic [AW:0]           rd_gray_w;
   logic                  full;
   logic [AW:0]           rd_ptr;
   logic [AW:0]           rd_gray;
   logic [AW:0]           wr_gray_r1;
   logic [AW:0]           wr_gray_r;
   logic                  empty;
   logic [AW:0]           fill_cnt;
   logic [3:0]            fill_thr;
   logic                  fill_done;   // Initial fill reached once
   rd_state_t             rd_state;
   logic                  rd_load;
   rx_pack_t              mem_out;
   rx_pack_t              swap_out;

   function automatic logic [AW:0] bin2gray(input logic [AW:0] b);
      return b ^ (b >> 1);
   endfunction

   function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
      logic [AW:0] b;
      b[AW] = g[AW];
      for (int i = AW - 1; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // Reset release, one synchronizer per clock
   always_ff @(posedge rxfifo_wrclk or negedge arst_n) begin
      if (!arst_n) begin
         wr_rst_sync <= 2'b00;
      end else begin
         wr_rst_sync <= {wr_rst_sync[0], 1'b1};
      end
   end

   always_ff @(posedge m_rd_clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_rst_sync <= 2'b00;
      end else begin
         rd_rst_sync <= {rd_rst_sync[0], 1'b1};
      end
   end

   assign wr_rst_n  = wr_rst_sync[1];
   assign rd_rst_n  = rd_rst_sync[1];
   assign mode_4to1 = (cfg.fifo_mode == 2'd1);

   // Packing control, sof restarts a group
   always_ff @(posedge rxfifo_wrclk or negedge wr_rst_n) begin
      if (!wr_rst_n) begin
         pack_cnt <= '0;
         wr_push  <= 1'b0;
      end else begin
         wr_push <= 1'b0;
         if (wa_beat.valid) begin
            if (!mode_4to1) begin
               wr_push <= 1'b1;
            end else if (wa_beat.sof) begin
               pack_cnt <= CW'(1);
            end else if (pack_cnt != '0) begin  // No group open means drop
               pack_cnt <= (pack_cnt == LAST) ? '0 : pack_cnt + 1'b1;
               wr_push  <= (pack_cnt == LAST);
            end
         end
      end
   end

   always_ff @(posedge rxfifo_wrclk) begin
      if (wa_beat.valid) begin
         if (!mode_4to1) begin
            wr_data <= {{(PACK-1)*WW{1'b0}}, dec_word};
         end else if (wa_beat.sof) begin
            pack_buf[0] <= dec_word;
         end else if (pack_cnt == LAST) begin
            wr_data <= {dec_word, pack_buf};  // Oldest word ends up lowest
         end else begin
            pack_buf[pack_cnt] <= dec_word;
         end
      end
   end

   always_ff @(posedge rxfifo_wrclk) begin
      if (wr_push && !full) begin
         mem[wr_ptr[AW-1:0]] <= wr_data;
      end
   end

   assign full = (wr_gray == {~rd_gray_w[AW:AW-1], rd_gray_w[AW-2:0]});

   always_ff @(posedge rxfifo_wrclk or negedge wr_rst_n) begin
      if (!wr_rst_n) begin
         wr_ptr        <= '0;
         wr_gray       <= '0;
         rd_gray_w1    <= '0;
         rd_gray_w     <= '0;
         fifo_overflow <= 1'b0;
      end else begin
         rd_gray_w1 <= rd_gray;
         rd_gray_w  <= rd_gray_w1;
         if (wr_push) begin
            if (full) begin
               fifo_overflow <= 1'b1;  // Link cannot stall, entry is lost
            end else begin
               wr_ptr  <= wr_ptr + 1'b1;
               wr_gray <= bin2gray(wr_ptr + 1'b1);
            end
         end
      end
   end

   assign empty    = (rd_gray == wr_gray_r);
   assign fill_cnt = gray2bin(wr_gray_r) - rd_ptr;
   assign fill_thr = (cfg.rd_delay == 4'd0) ? 4'd1 : cfg.rd_delay;
   assign rd_load  = (rd_state == RD_IDLE) && fill_done && !empty;

   always_ff @(posedge m_rd_clk or negedge rd_rst_n) begin
      if (!rd_rst_n) begin
         wr_gray_r1 <= '0;
         wr_gray_r  <= '0;
         fill_done  <= 1'b0;
         rd_ptr     <= '0;
         rd_gray    <= '0;
         rd_req     <= 1'b0;
         rd_state   <= RD_IDLE;
      end else begin
         wr_gray_r1 <= wr_gray;
         wr_gray_r  <= wr_gray_r1;
         if (int'(fill_cnt) >= int'(fill_thr)) begin
            fill_done <= 1'b1;
         end
         case (rd_state)
            RD_IDLE: begin
               if (rd_load) begin
                  rd_req   <= 1'b1;
                  rd_state <= RD_REQ;
               end
            end
            RD_REQ: begin
               if (rd_ack) begin
                  rd_req   <= 1'b0;
                  rd_ptr   <= rd_ptr + 1'b1;  // Entry taken, slot freed
                  rd_gray  <= bin2gray(rd_ptr + 1'b1);
                  rd_state <= RD_RELEASE;
               end
            end
            default: begin
               if (!rd_ack) begin
                  rd_state <= RD_IDLE;
               end
            end
         endcase
      end
   end

   assign mem_out = mem[rd_ptr[AW-1:0]];

   // Half swap keeps both top bits in place
   always_comb begin
      swap_out = mem_out;
      if (mode_4to1 && cfg.swap_en) begin
         swap_out[WW-1:0] = {mem_out[WW-1], mem_out[HW-2:0], mem_out[HW-1], mem_out[WW-2:HW]};
      end
   end

   // Held until the consumer releases rd_ack
   always_ff @(posedge m_rd_clk) begin
      if (rd_load) begin
         rd_data <= swap_out;
      end
   end

endmodule

// File: source/aib_rx_channel.sv
// Die-to-die receive channel
`timescale 1ns/10ps

module aib_rx_channel (
   input  logic                   rxfifo_wrclk,
   input  logic                   m_rd_clk,
   input  logic                   arst_n,
   input  aib_rx_pkg::rx_word_t   din,
   input  aib_rx_pkg::rx_cfg_t    cfg,
   input  logic                   rd_ack,
   output aib_rx_pkg::rx_word_t   data_out,
   output aib_rx_pkg::rx_pack_t   rd_data,
   output logic                   rd_req,
   output aib_rx_pkg::rx_status_t status
);
   import aib_rx_pkg::*;

   rx_word_t   dec_word;
   rx_beat_t   wa_beat;
   logic       align_done;
   logic       wa_error;
   logic [3:0] wa_error_cnt;
   logic       fifo_overflow;

   // Decoded word also leaves unbuffered
   assign data_out = dec_word;

   assign status = rx_status_t'{
      align_done:    align_done,
      wa_error:      wa_error,
      wa_error_cnt:  wa_error_cnt,
      fifo_overflow: fifo_overflow
   };

   aib_rx_dbi_decoder i_dbi_decoder (
      .rxfifo_wrclk (rxfifo_wrclk),
      .arst_n       (arst_n),
      .din          (din),
      .dbi_en       (cfg.dbi_en),
      .dec_word     (dec_word)
   );

   // Sees the raw word, the marker is not DBI coded
   aib_rx_word_aligner i_word_aligner (
      .rxfifo_wrclk (rxfifo_wrclk),
      .arst_n       (arst_n),
      .din          (din),
      .cfg          (cfg),
      .wa_beat      (wa_beat),
      .align_done   (align_done),
      .wa_error     (wa_error),
      .wa_error_cnt (wa_error_cnt)
   );

   aib_rx_fifo i_fifo (
      .rxfifo_wrclk  (rxfifo_wrclk),
      .m_rd_clk      (m_rd_clk),
      .arst_n        (arst_n),
      .cfg           (cfg),
      .dec_word      (dec_word),
      .wa_beat       (wa_beat),
      .rd_data       (rd_data),
      .rd_req        (rd_req),
      .rd_ack        (rd_ack),
      .fifo_overflow (fifo_overflow)
   );

endmodule

// File: test/tb_aib_rx_channel.sv
// Receive channel testbench
`timescale 1ns/10ps
`include "aib_rx_config.svh"

module tb_aib_rx_channel;
   import aib_rx_pkg::*;

   localparam int WW      = `AIB_RX_WORD_W;
   localparam int LW      = `AIB_RX_LANE_W;
   localparam int DEPTH   = 1 << `AIB_RX_FIFO_AW;
   localparam int MAX_CYC = 3000;  // Write cycles allowed per phase
   localparam int ACK_TO  = 50;    // Read cycles for rd_req to drop

   logic       rxfifo_wrclk = 1'b0;
   logic       m_rd_clk = 1'b0;
   logic       arst_n;
   rx_word_t   din;
   rx_cfg_t    cfg;
   logic       rd_ack;
   rx_word_t   data_out;
   rx_pack_t   rd_data;
   logic       rd_req;
   rx_status_t status;

   integer     seed = 32'heb5ec484;
   rx_pack_t   exp_q [$];      // Expected read words in write order
   time        push_time [$];  // When each expected entry was sent
   int         exp_idx;        // Model index of the exp_q front
   int         rx_count;
   bit         req_seen;
   bit         stall;          // Consumer ignores rd_req

   // Rising edges never coincide between the two clocks
   always #5 rxfifo_wrclk = ~rxfifo_wrclk;
   always #6.5 m_rd_clk = ~m_rd_clk;

   aib_rx_channel i_dut (
      .rxfifo_wrclk (rxfifo_wrclk),
      .m_rd_clk     (m_rd_clk),
      .arst_n       (arst_n),
      .din          (din),
      .cfg          (cfg),
      .rd_ack       (rd_ack),
      .data_out     (data_out),
      .rd_data      (rd_data),
      .rd_req       (rd_req),
      .status       (status)
   );

   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("*** FAILED ***");
      $fatal(1);
   endtask

   function automatic rx_word_t random_word();
      logic [95:0] r;
      r = {$random(seed), $random(seed), $random(seed)};
      return r[WW-1:0];
   endfunction

   // Each lane's top bit tells whether its other bits arrive inverted
   function automatic rx_word_t decode_dbi(input rx_word_t w, input logic en);
      rx_word_t r;
      r = w;
      if (en) begin
         for (int b = 0; b < WW; b++) begin
            if (b % LW == LW - 1) begin
               r[b] = 1'b0;
            end else begin
               r[b] = w[b] ^ w[(b / LW) * LW + LW - 1];
            end
         end
      end
      return r;
   endfunction

   // Bits 79 and 39 stay, the two 39-bit halves trade places
   function automatic rx_pack_t swap_low(input rx_pack_t p);
      rx_pack_t r;
      r = p;
      for (int b = 0; b < 39; b++) begin
         r[b]      = p[b + 40];
         r[b + 40] = p[b];
      end
      return r;
   endfunction

   function automatic rx_cfg_t build_cfg(input logic [1:0] mode, input logic [3:0] delay,
                                         input logic wa, input logic swap,
                                         input logic [4:0] mk, input logic dbi);
      rx_cfg_t c;
      c.fifo_mode = mode;
      c.rd_delay  = delay;
      c.wa_en     = wa;
      c.swap_en   = swap;
      c.mkbit     = mk;
      c.dbi_en    = dbi;
      return c;
   endfunction

   // Rule of the phase compensation fill
   task automatic check_fill();
      int thr;
      thr = (cfg.rd_delay == 4'd0) ? 1 : int'(cfg.rd_delay);
      assert (push_time.size() >= thr && push_time[thr-1] + 40 <= $time) else
         stop_with_failure($sformatf("CHECK FAILED at %0t: rd_req before %0d entries written",
                                     $time, thr));
   endtask

   task automatic compare_read(input rx_pack_t got);
      rx_pack_t exp;
      bit       found;
      found = 1'b0;
      while (!found && exp_q.size() > 0) begin
         exp = exp_q.pop_front();
         // Entries go missing only after the FIFO has been full
         assert (exp == got || (status.fifo_overflow && exp_idx >= DEPTH)) else
            stop_with_failure($sformatf("CHECK FAILED at %0t: read %0d is %h, expected %h",
                                        $time, rx_count, got, exp));
         found = (exp == got);
         exp_idx++;
      end
      assert (found) else
         stop_with_failure($sformatf("CHECK FAILED at %0t: read %0d %h matches no written word",
                                     $time, rx_count, got));
      rx_count++;
   endtask

   task automatic apply_reset(input rx_cfg_t c);
      @(posedge rxfifo_wrclk);
      #1;
      arst_n = 1'b0;
      din    = '0;
      cfg    = c;
      exp_q.delete();
      push_time.delete();
      exp_idx  = 0;
      rx_count = 0;
      req_seen = 1'b0;
      repeat (10) @(posedge rxfifo_wrclk);
      #1;
      arst_n = 1'b1;
      @(posedge rxfifo_wrclk);  // Release goes through two flops
      #1;
      assert (rd_req == 1'b0 && status == '0) else
         stop_with_failure($sformatf("CHECK FAILED at %0t: rd_req %b status %h after reset",
                                     $time, rd_req, status));
   endtask

   // Drives words until enough reads came back and all errors went out
   task automatic run_traffic(input int lead, input int inject, input int target);
      rx_word_t w;
      rx_word_t prev;
      rx_word_t grp [4];
      rx_pack_t entry;
      int       sent;
      int       pos;
      int       errs;
      int       cycles;
      bit       marked;
      bit       grouped;
      bit       done;
      grouped = (cfg.fifo_mode == 2'd1) && cfg.wa_en;
      prev    = '0;
      sent    = 0;
      errs    = 0;
      cycles  = 0;
      marked  = 1'b0;
      done    = 1'b0;
      while (!done) begin
         @(posedge rxfifo_wrclk);
         #1;
         cycles++;
         if (cycles > MAX_CYC) begin
            stop_with_failure("Timeout: read words or alignment errors did not arrive");
         end
         assert (data_out == decode_dbi(prev, cfg.dbi_en)) else
            stop_with_failure($sformatf("CHECK FAILED at %0t: data_out %h, expected %h",
                                        $time, data_out, decode_dbi(prev, cfg.dbi_en)));
         assert (status.align_done == marked && status.wa_error == (errs > 0) &&
                 status.wa_error_cnt == ((errs > 15) ? 15 : errs)) else
            stop_with_failure($sformatf("CHECK FAILED at %0t: status %h, errors sent %0d",
                                        $time, status, errs));
         // Stalled reads, the ninth entry finds the FIFO full
         assert (!stall || push_time.size() <= DEPTH + 1 || status.fifo_overflow) else
            stop_with_failure($sformatf("CHECK FAILED at %0t: no fifo_overflow after %0d entries",
                                        $time, push_time.size()));
         if (stall && status.fifo_overflow) begin
            stall = 1'b0;
         end
         if (rx_count >= target && errs >= inject) begin
            done = 1'b1;
         end else begin
            w = random_word();
            if (!grouped) begin
               exp_q.push_back({{(`AIB_RX_PACK-1)*WW{1'b0}}, decode_dbi(w, cfg.dbi_en)});
               push_time.push_back($time);
            end else if (sent < lead) begin
               w[cfg.mkbit] = 1'b0;  // Junk before the marker
            end else begin
               pos          = (sent - lead) % 4;
               w[cfg.mkbit] = (pos == 0);
               // Misplaced marker, never on the very first marker word
               if (sent > lead && errs < inject && ($random(seed) & 1) == 1) begin
                  w[cfg.mkbit] = (pos != 0);
                  errs++;
               end
               grp[pos] = decode_dbi(w, cfg.dbi_en);
               marked   = 1'b1;
               if (pos == 3) begin
                  entry = {grp[3], grp[2], grp[1], grp[0]};
                  exp_q.push_back(cfg.swap_en ? swap_low(entry) : entry);
                  push_time.push_back($time);
               end
            end
            din  = w;
            prev = w;
            sent++;
         end
      end
   endtask

   // Read side order and data hold
   assert property (@(posedge m_rd_clk) disable iff (!arst_n)
                    $rose(rd_req) |-> !$past(rd_ack))
      else stop_with_failure($sformatf("CHECK FAILED at %0t: rd_req rose with rd_ack high",
                                       $time));
   assert property (@(posedge m_rd_clk) disable iff (!arst_n)
                    $past(rd_req || rd_ack) |-> $stable(rd_data))
      else stop_with_failure($sformatf("CHECK FAILED at %0t: rd_data changed in a transfer",
                                       $time));

   initial begin : consumer
      int d;
      int n;
      rd_ack = 1'b0;
      forever begin
         @(posedge m_rd_clk);
         #1;
         if (rd_req && !req_seen) begin
            req_seen = 1'b1;
            check_fill();
         end
         if (rd_req && !stall) begin
            compare_read(rd_data);
            d = $unsigned($random(seed)) % 4;
            for (int i = 0; i < d; i++) begin
               @(posedge m_rd_clk);
               #1;
            end
            rd_ack = 1'b1;
            n = 0;
            while (rd_req) begin
               @(posedge m_rd_clk);
               #1;
               n++;
               if (n > ACK_TO) begin
                  stop_with_failure("Timeout: rd_req stayed high after rd_ack");
               end
            end
            // Release may trail the end of the request
            d = $unsigned($random(seed)) % 4;
            for (int i = 0; i < d; i++) begin
               @(posedge m_rd_clk);
               #1;
            end
            rd_ack = 1'b0;
         end
      end
   end

   initial begin : stimulus
      arst_n   = 1'b0;
      din      = '0;
      cfg      = '0;
      stall    = 1'b0;
      exp_idx  = 0;
      rx_count = 0;
      req_seen = 1'b0;

      // 1:1 with and without DBI
      apply_reset(build_cfg(2'd0, 4'd0, 1'b0, 1'b0, 5'd0, 1'b1));
      run_traffic(0, 0, 6);
      apply_reset(build_cfg(2'd0, 4'd0, 1'b0, 1'b0, 5'd0, 1'b0));
      run_traffic(0, 0, 4);

      // 4:1 alignment, clean and with misplaced markers
      apply_reset(build_cfg(2'd1, 4'd0, 1'b1, 1'b0, 5'd7, 1'b1));
      run_traffic(5, 0, 5);
      apply_reset(build_cfg(2'd1, 4'd0, 1'b1, 1'b0, 5'd23, 1'b1));
      run_traffic(3, 6, 3);
      apply_reset(build_cfg(2'd1, 4'd0, 1'b1, 1'b0, 5'd19, 1'b1));
      run_traffic(4, 20, 3);

      // Half swap
      apply_reset(build_cfg(2'd1, 4'd0, 1'b1, 1'b1, 5'd31, 1'b1));
      run_traffic(3, 0, 5);

      // Fill of three, then a stalled consumer
      apply_reset(build_cfg(2'd1, 4'd3, 1'b1, 1'b0, 5'd2, 1'b0));
      stall = 1'b1;
      run_traffic(2, 0, 10);

      $display("*** PASSED ***");
      $finish;
   end

endmodule

// File: aib_rx_channel.f
+incdir+source
source/aib_rx_pkg.sv
source/aib_rx_dbi_decoder.sv
source/aib_rx_word_aligner.sv
source/aib_rx_fifo.sv
source/aib_rx_channel.sv
test/tb_aib_rx_channel.sv

// File: Bender.yml
package:
  name: aib_rx_channel

export_include_dirs:
  - source

sources:
  - files:
      - source/aib_rx_pkg.sv
      - source/aib_rx_dbi_decoder.sv
      - source/aib_rx_word_aligner.sv
      - source/aib_rx_fifo.sv
      - source/aib_rx_channel.sv
  - target: test
    files:
      - test/tb_aib_rx_channel.sv
